// File: Makefile
# Verilator build for the TinyRV1 pipelined processor

VERILATOR ?= verilator
TOP       ?= proc_tb
RTL_TOP   ?= proc
FILELIST  ?= proc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass message appears on a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/proc.sv
`default_nettype none

module proc (
  input  logic        clk,
  input  logic        rst,

  // Instruction memory
  output logic        imemreq_val,
  output logic [31:0] imemreq_addr,
  input  logic [31:0] imemresp_data,

  // Data memory
  output logic        dmemreq_val,
  output logic        dmemreq_type,   // 1 for a store
  output logic [31:0] dmemreq_addr,
  output logic [31:0] dmemreq_wdata,
  input  logic [31:0] dmemresp_rdata
);

  proc_ctrl_if ctrl_if ();

  proc_ctrl ctrl_i (
    .clk (clk),
    .rst (rst),
    .c   (ctrl_if.ctrl)
  );

  proc_dpath dpath_i (
    .clk            (clk),
    .rst            (rst),
    .d              (ctrl_if.dpath),
    .imemreq_addr   (imemreq_addr),
    .imemresp_data  (imemresp_data),
    .dmemreq_addr   (dmemreq_addr),
    .dmemreq_wdata  (dmemreq_wdata),
    .dmemresp_rdata (dmemresp_rdata)
  );

  assign imemreq_val  = ctrl_if.reg_en_f;   // No new fetch while stalled
  assign dmemreq_val  = ctrl_if.dmemreq_val_m;
  assign dmemreq_type = ctrl_if.dmemreq_type_m;

endmodule

`default_nettype wire

// File: hw/proc_alu.sv
`default_nettype none

module proc_alu import tinyrv1_pkg::*; (
  input  logic [31:0] op1,
  input  logic [31:0] op2,
  input  result_sel_e result_sel,
  output logic [31:0] result,
  output logic        eq
);

  logic [31:0] sum;
  logic [31:0] prod;

  assign sum  = op1 + op2;
  assign prod = op1 * op2;   // Low word only

  always_comb begin
    case (result_sel)
      res_mul: result = prod;
      default: result = sum;
    endcase
  end

  // BNE compare
  assign eq = (op1 == op2);

endmodule

`default_nettype wire

// File: hw/proc_ctrl.sv
`default_nettype none

module proc_ctrl import tinyrv1_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  proc_ctrl_if.ctrl  c
);

  logic              val_d;
  logic              val_x;
  logic              val_m;
  logic              val_w;
  logic [31:0]       inst_x;
  logic [31:0]       inst_m;
  logic [31:0]       inst_w;

  logic [reg_aw-1:0] rs1_d;
  logic [reg_aw-1:0] rs2_d;
  logic [reg_aw-1:0] rd_x;
  logic [reg_aw-1:0] rd_m;
  logic [reg_aw-1:0] rd_w;
  logic              rs1_en_d;
  logic              rs2_en_d;
  logic              jal_d;
  logic              jr_d;
  logic              lw_x;
  logic              br_taken_x;
  logic              stall_d;
  logic              jump_d;
  logic              squash_f;

  function automatic logic writes_rd(input logic [31:0] inst);
    return (inst ==? op_add) | (inst ==? op_addi) | (inst ==? op_mul) |
           (inst ==? op_lw)  | (inst ==? op_jal);
  endfunction

  // X over M over W, x0 never bypassed
  function automatic byp_sel_e byp_pick(input logic [reg_aw-1:0] rs, input logic en);
    byp_sel_e sel;
    sel = byp_rf;
    if (en && rs != '0) begin
      if (val_w && writes_rd(inst_w) && rs == rd_w) sel = byp_w;
      if (val_m && writes_rd(inst_m) && rs == rd_m) sel = byp_m;
      if (val_x && writes_rd(inst_x) && !lw_x && rs == rd_x) sel = byp_x;
    end
    return sel;
  endfunction

  // ==========================================================
  // Valid and instruction pipeline
  // ==========================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      val_d <= 1'b0;
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      if (c.reg_en_d) val_d <= ~squash_f;   // Holds through a stall
      val_x <= val_d & ~c.squash_d;
      val_m <= val_x;
      val_w <= val_m;
    end
  end

  always_ff @(posedge clk) begin
    inst_x <= c.inst_d;
    inst_m <= inst_x;
    inst_w <= inst_m;
  end

  assign rs1_d = c.inst_d[rs1_lsb +: reg_aw];
  assign rs2_d = c.inst_d[rs2_lsb +: reg_aw];
  assign rd_x  = inst_x[rd_lsb +: reg_aw];
  assign rd_m  = inst_m[rd_lsb +: reg_aw];
  assign rd_w  = inst_w[rd_lsb +: reg_aw];

  // ==========================================================
  // Hazards
  // ==========================================================

  assign lw_x       = inst_x ==? op_lw;
  assign br_taken_x = val_x & (inst_x ==? op_bne) & ~c.eq_x;

  // Load result not ready until M
  assign stall_d = val_d & val_x & lw_x & (rd_x != '0) &
                   ((rs1_en_d & (rs1_d == rd_x)) | (rs2_en_d & (rs2_d == rd_x)));

  assign jump_d   = val_d & ~stall_d & (jal_d | jr_d);
  assign squash_f = br_taken_x | jump_d;

  assign c.squash_d = stall_d | br_taken_x;
  assign c.reg_en_f = ~stall_d;
  assign c.reg_en_d = ~stall_d;

  always_comb begin
    if (br_taken_x)           c.pc_sel_f = pc_br;   // Oldest redirect wins
    else if (jump_d && jal_d) c.pc_sel_f = pc_jal;
    else if (jump_d)          c.pc_sel_f = pc_jr;
    else                      c.pc_sel_f = pc_plus4;
  end

  // ==========================================================
  // Decode
  // ==========================================================

  always_comb begin
    rs1_en_d     = 1'b0;
    rs2_en_d     = 1'b0;
    jal_d        = 1'b0;
    jr_d         = 1'b0;
    c.imm_type_d = imm_i;
    c.op1_sel_d  = op1_rf;
    c.op2_sel_d  = op2_rf;
    casez (c.inst_d)
      op_add, op_mul: begin
        rs1_en_d = 1'b1;
        rs2_en_d = 1'b1;
      end
      op_addi, op_lw: begin
        rs1_en_d    = 1'b1;
        c.op2_sel_d = op2_imm;
      end
      op_sw: begin
        rs1_en_d     = 1'b1;
        rs2_en_d     = 1'b1;   // Store data
        c.imm_type_d = imm_s;
        c.op2_sel_d  = op2_imm;
      end
      op_jal: begin
        jal_d        = 1'b1;
        c.imm_type_d = imm_j;
        c.op1_sel_d  = op1_pc;
      end
      op_jr: begin
        rs1_en_d = 1'b1;
        jr_d     = 1'b1;
      end
      op_bne: begin
        rs1_en_d     = 1'b1;
        rs2_en_d     = 1'b1;
        c.imm_type_d = imm_b;
      end
      default: ;
    endcase
  end

  always_comb begin
    c.op1_byp_sel_d = byp_pick(rs1_d, rs1_en_d);
    c.op2_byp_sel_d = byp_pick(rs2_d, rs2_en_d);
  end

  // X, M, W selects
  always_comb begin
    casez (inst_x)
      op_mul:  c.result_sel_x = res_mul;
      default: c.result_sel_x = res_alu;
    endcase
  end

  always_comb begin
    c.dmemreq_val_m  = 1'b0;
    c.dmemreq_type_m = mem_read;
    c.wb_sel_m       = wb_result;
    casez (inst_m)
      op_lw: begin
        c.dmemreq_val_m = val_m;
        c.wb_sel_m      = wb_load;
      end
      op_sw: begin
        c.dmemreq_val_m  = val_m;
        c.dmemreq_type_m = mem_write;
      end
      default: ;
    endcase
  end

  assign c.rf_wen_w   = val_w & writes_rd(inst_w);
  assign c.rf_waddr_w = rd_w;

endmodule

`default_nettype wire

// File: hw/proc_ctrl_if.sv
`default_nettype none

interface proc_ctrl_if import tinyrv1_pkg::*; ();

  // Control, per stage
  logic              reg_en_f;
  pc_sel_e           pc_sel_f;
  logic              reg_en_d;
  logic              squash_d;       // Bubble into X
  imm_type_e         imm_type_d;
  byp_sel_e          op1_byp_sel_d;
  byp_sel_e          op2_byp_sel_d;
  op1_sel_e          op1_sel_d;
  op2_sel_e          op2_sel_d;
  result_sel_e       result_sel_x;
  logic              dmemreq_val_m;
  mem_type_e         dmemreq_type_m;
  wb_sel_e           wb_sel_m;
  logic              rf_wen_w;
  logic [reg_aw-1:0] rf_waddr_w;

  // Status back to the control unit
  logic [31:0]       inst_d;
  logic              eq_x;

  modport ctrl (
    output reg_en_f, pc_sel_f, reg_en_d, squash_d,
    output imm_type_d, op1_byp_sel_d, op2_byp_sel_d, op1_sel_d, op2_sel_d,
    output result_sel_x, dmemreq_val_m, dmemreq_type_m, wb_sel_m,
    output rf_wen_w, rf_waddr_w,
    input  inst_d, eq_x
  );

  modport dpath (
    input  reg_en_f, pc_sel_f, reg_en_d, squash_d,
    input  imm_type_d, op1_byp_sel_d, op2_byp_sel_d, op1_sel_d, op2_sel_d,
    input  result_sel_x, dmemreq_val_m, dmemreq_type_m, wb_sel_m,
    input  rf_wen_w, rf_waddr_w,
    output inst_d, eq_x
  );

endinterface

`default_nettype wire

// File: hw/proc_dpath.sv
`default_nettype none

module proc_dpath import tinyrv1_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  proc_ctrl_if.dpath  d,
  output logic [31:0] imemreq_addr,
  input  logic [31:0] imemresp_data,
  output logic [31:0] dmemreq_addr,
  output logic [31:0] dmemreq_wdata,
  input  logic [31:0] dmemresp_rdata
);

  logic [31:0] pc_f;
  logic [31:0] pc_next_f;
  logic [31:0] ir_d;
  logic [31:0] pc_d;
  logic [31:0] imm_d;
  logic [31:0] rf_rdata0;
  logic [31:0] rf_rdata1;
  logic [31:0] op1_byp_d;
  logic [31:0] op2_byp_d;
  logic [31:0] op1_d;
  logic [31:0] op2_d;
  logic [31:0] targ_d;
  logic [31:0] op1_x;
  logic [31:0] op2_x;
  logic [31:0] sd_x;
  logic [31:0] br_targ_x;
  logic [31:0] result_x;
  logic [31:0] result_m;
  logic [31:0] sd_m;
  logic [31:0] wb_m;
  logic [31:0] wb_w;

  function automatic logic [31:0] byp_mux(input byp_sel_e sel, input logic [31:0] rf_val);
    case (sel)
      byp_x:   return result_x;
      byp_m:   return wb_m;
      byp_w:   return wb_w;
      default: return rf_val;
    endcase
  endfunction

  // ==========================================================
  // Fetch
  // ==========================================================

  always_comb begin
    case (d.pc_sel_f)
      pc_jal:  pc_next_f = targ_d;
      pc_jr:   pc_next_f = {op1_byp_d[31:1], 1'b0};
      pc_br:   pc_next_f = br_targ_x;
      default: pc_next_f = pc_f + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)             pc_f <= reset_pc;
    else if (d.reg_en_f) pc_f <= pc_next_f;
  end

  assign imemreq_addr = pc_f;

  // ==========================================================
  // Decode
  // ==========================================================

  always_ff @(posedge clk) begin
    if (d.reg_en_d) begin
      ir_d <= imemresp_data;
      pc_d <= pc_f;
    end
  end

  assign d.inst_d = ir_d;

  proc_regfile regfile_i (
    .clk    (clk),
    .raddr0 (ir_d[rs1_lsb +: reg_aw]),
    .rdata0 (rf_rdata0),
    .raddr1 (ir_d[rs2_lsb +: reg_aw]),
    .rdata1 (rf_rdata1),
    .wen    (d.rf_wen_w),
    .waddr  (d.rf_waddr_w),
    .wdata  (wb_w)
  );

  always_comb begin
    case (d.imm_type_d)
      imm_s:   imm_d = {{20{ir_d[31]}}, ir_d[31:25], ir_d[11:7]};
      imm_j:   imm_d = {{12{ir_d[31]}}, ir_d[19:12], ir_d[20], ir_d[30:21], 1'b0};
      imm_b:   imm_d = {{20{ir_d[31]}}, ir_d[7], ir_d[30:25], ir_d[11:8], 1'b0};
      default: imm_d = {{20{ir_d[31]}}, ir_d[31:20]};
    endcase
  end

  assign op1_byp_d = byp_mux(d.op1_byp_sel_d, rf_rdata0);
  assign op2_byp_d = byp_mux(d.op2_byp_sel_d, rf_rdata1);
  assign targ_d    = pc_d + imm_d;   // JAL target, BNE target

  // Link value PC+4 passes the adder with a zero op2
  assign op1_d = (d.op1_sel_d == op1_pc) ? pc_d + 32'd4 : op1_byp_d;
  always_comb begin
    if (d.op2_sel_d == op2_imm)     op2_d = imm_d;
    else if (d.op1_sel_d == op1_pc) op2_d = 32'd0;
    else                            op2_d = op2_byp_d;
  end

  // ==========================================================
  // Execute, memory, writeback
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!d.squash_d) begin
      op1_x     <= op1_d;
      op2_x     <= op2_d;
      sd_x      <= op2_byp_d;
      br_targ_x <= targ_d;
    end
  end

  proc_alu alu_i (
    .op1        (op1_x),
    .op2        (op2_x),
    .result_sel (d.result_sel_x),
    .result     (result_x),
    .eq         (d.eq_x)
  );

  always_ff @(posedge clk) begin
    result_m <= result_x;
    sd_m     <= sd_x;
    wb_w     <= wb_m;
  end

  assign dmemreq_addr  = result_m;
  assign dmemreq_wdata = sd_m;
  assign wb_m = (d.wb_sel_m == wb_load) ? dmemresp_rdata : result_m;

endmodule

`default_nettype wire

// File: hw/proc_regfile.sv
`default_nettype none

module proc_regfile import tinyrv1_pkg::*; (
  input  logic              clk,
  input  logic [reg_aw-1:0] raddr0,
  output logic [31:0]       rdata0,
  input  logic [reg_aw-1:0] raddr1,
  output logic [31:0]       rdata1,
  input  logic              wen,
  input  logic [reg_aw-1:0] waddr,
  input  logic [31:0]       wdata
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 hardwired to zero
  assign rdata0 = (raddr0 == '0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? 32'd0 : regs[raddr1];

endmodule

`default_nettype wire

// File: hw/tinyrv1_pkg.sv
`default_nettype none

package tinyrv1_pkg;

  // ==========================================================
  // Reset vector and instruction fields
  // ==========================================================

  localparam logic [31:0] reset_pc = 32'h0000_0200;

  localparam int unsigned reg_aw  = 5;   // Register specifier width
  localparam int unsigned rd_lsb  = 7;
  localparam int unsigned rs1_lsb = 15;
  localparam int unsigned rs2_lsb = 20;

  // ==========================================================
  // Opcode match patterns where ? marks a don't-care bit
  // ==========================================================

  localparam logic [31:0] op_add  = 32'b0000000_?????_?????_000_?????_0110011;
  localparam logic [31:0] op_addi = 32'b????????????_?????_000_?????_0010011;
  localparam logic [31:0] op_mul  = 32'b0000001_?????_?????_000_?????_0110011;
  localparam logic [31:0] op_lw   = 32'b????????????_?????_010_?????_0000011;
  localparam logic [31:0] op_sw   = 32'b???????_?????_?????_010_?????_0100011;
  localparam logic [31:0] op_jal  = 32'b????????????????????_?????_1101111;
  localparam logic [31:0] op_jr   = 32'b000000000000_?????_000_00000_1100111; // JALR x0, 0
  localparam logic [31:0] op_bne  = 32'b???????_?????_?????_001_?????_1100011;

  // ==========================================================
  // Datapath select encodings
  // ==========================================================

  typedef enum logic [1:0] {
    imm_i,
    imm_s,
    imm_j,
    imm_b
  } imm_type_e;

  typedef enum logic [1:0] {
    pc_plus4,
    pc_jal,   // Target computed in D
    pc_jr,    // rs1 value in D
    pc_br     // Taken BNE resolved in X
  } pc_sel_e;

  typedef enum logic [1:0] {
    byp_rf,
    byp_x,
    byp_m,
    byp_w
  } byp_sel_e;

  typedef enum logic {wb_result, wb_load} wb_sel_e;
  typedef enum logic {res_alu, res_mul} result_sel_e;
  typedef enum logic {op2_rf, op2_imm} op2_sel_e;
  typedef enum logic {op1_rf, op1_pc} op1_sel_e;   // op1_pc carries the JAL link
  typedef enum logic {mem_read, mem_write} mem_type_e;

endpackage

`default_nettype wire

// File: proc.f
hw/tinyrv1_pkg.sv
hw/proc_ctrl_if.sv
hw/proc_ctrl.sv
hw/proc_regfile.sv
hw/proc_alu.sv
hw/proc_dpath.sv
hw/proc.sv
tb/proc_tb.sv

// File: tb/proc_tb.sv
`default_nettype none

module proc_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // ==========================================================
  // Program layout and test table
  // ==========================================================

  localparam int n_dir       = 9;
  localparam int n_rand      = 10;
  localparam int n_rows      = n_dir + n_rand;
  localparam int row_limit   = 150;   // Cycles to wait for the result store
  localparam int watchdog_ns = n_rows * 200 * 10;

  localparam logic [31:0] prog_base  = 32'h0000_0200;
  localparam int          base_idx   = (prog_base >> 2) % 256;
  localparam logic [31:0] jal_addr   = prog_base + 32'h4;
  localparam logic [31:0] a_addr     = 32'h0000_0100;
  localparam logic [31:0] b_addr     = 32'h0000_0104;
  localparam logic [31:0] res_addr   = 32'h0000_0108;
  localparam logic [31:0] stray_addr = 32'h0000_010c;   // Only a leaked JR shadow stores here

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  localparam logic [2:0] t_add  = 3'd0;
  localparam logic [2:0] t_mul  = 3'd1;
  localparam logic [2:0] t_addi = 3'd2;
  localparam logic [2:0] t_bne  = 3'd3;
  localparam logic [2:0] t_jal  = 3'd4;

  typedef struct packed {
    logic [2:0]  tmpl;
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [31:0] expected;
  } row_t;

  logic        clk;
  logic        rst;
  logic        imemreq_val;
  logic [31:0] imemreq_addr;
  logic [31:0] imemresp_data;
  logic        dmemreq_val;
  logic        dmemreq_type;
  logic [31:0] dmemreq_addr;
  logic [31:0] dmemreq_wdata;
  logic [31:0] dmemresp_rdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  row_t        rows [n_rows];
  int          row_cnt;
  int          errors;
  logic [31:0] rng;

  proc dut_i (
    .clk            (clk),
    .rst            (rst),
    .imemreq_val    (imemreq_val),
    .imemreq_addr   (imemreq_addr),
    .imemresp_data  (imemresp_data),
    .dmemreq_val    (dmemreq_val),
    .dmemreq_type   (dmemreq_type),
    .dmemreq_addr   (dmemreq_addr),
    .dmemreq_wdata  (dmemreq_wdata),
    .dmemresp_rdata (dmemresp_rdata)
  );

  // Both memories answer in the same cycle
  assign imemresp_data  = imem[imemreq_addr[9:2]];
  assign dmemresp_rdata = dmem[dmemreq_addr[9:2]];

  always #5 clk = ~clk;

  // ==========================================================
  // Instruction encoding and reference model
  // ==========================================================

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, opc_op};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Value each template stores to res_addr
  function automatic logic [31:0] ref_result(input logic [2:0] tmpl, input logic [31:0] a,
                                             input logic [31:0] b, input logic [11:0] imm);
    case (tmpl)
      t_add:   return a + b;
      t_mul:   return a * b;             // Low word of the product
      t_addi:  return a + sext12(imm) + sext12(b[11:0]);
      t_bne:   return (a != b) ? a : a + sext12(imm);
      default: return a + jal_addr + 32'd4;
    endcase
  endfunction

  // One consumer directly behind a load in these templates
  function automatic int load_use_stalls(input logic [2:0] tmpl);
    case (tmpl)
      t_add, t_mul, t_addi: return 1;
      default:              return 0;
    endcase
  endfunction

  task automatic add_row(input logic [2:0] tmpl, input logic [31:0] a, input logic [31:0] b,
                         input logic [11:0] imm, input logic [31:0] expected);
    rows[row_cnt].tmpl     = tmpl;
    rows[row_cnt].a        = a;
    rows[row_cnt].b        = b;
    rows[row_cnt].imm      = imm;
    rows[row_cnt].expected = expected;
    row_cnt++;
  endtask

  // ==========================================================
  // Memory loading
  // ==========================================================

  task automatic fill_memories();
    int i;
    for (i = 0; i < 256; i++) begin
      imem[i] = 32'(i) << 7;               // Zero opcode field decodes as nothing
      dmem[i] = 32'hd00d_0000 ^ 32'(i);
    end
  endtask

  task automatic load_row(input row_t row);
    fill_memories();
    dmem[a_addr[9:2]] = row.a;
    dmem[b_addr[9:2]] = row.b;
    imem[base_idx] = itype(a_addr[11:0], 5'd0, 3'b010, 5'd1, opc_load);   // lw x1
    case (row.tmpl)
      t_add, t_mul: begin
        imem[base_idx + 1] = itype(b_addr[11:0], 5'd0, 3'b010, 5'd2, opc_load);
        imem[base_idx + 2] = rtype((row.tmpl == t_mul) ? 7'h01 : 7'h00, 5'd2, 5'd1, 5'd3);
        imem[base_idx + 3] = stype(res_addr[11:0], 5'd3, 5'd0);
      end
      t_addi: begin
        imem[base_idx + 1] = itype(row.imm, 5'd1, 3'b000, 5'd2, opc_imm);
        imem[base_idx + 2] = itype(row.b[11:0], 5'd2, 3'b000, 5'd3, opc_imm);
        imem[base_idx + 3] = stype(res_addr[11:0], 5'd3, 5'd0);
      end
      t_bne: begin
        imem[base_idx + 1] = itype(b_addr[11:0], 5'd0, 3'b010, 5'd2, opc_load);
        imem[base_idx + 2] = itype(12'd0, 5'd1, 3'b000, 5'd3, opc_imm);
        imem[base_idx + 3] = btype(13'd8, 5'd2, 5'd1);                  // Skips the next ADDI
        imem[base_idx + 4] = itype(row.imm, 5'd3, 3'b000, 5'd3, opc_imm);
        imem[base_idx + 5] = stype(res_addr[11:0], 5'd3, 5'd0);
      end
      default: begin
        imem[base_idx + 1] = jtype(21'd16, 5'd5);                       // jal x5, sub
        imem[base_idx + 2] = itype(12'd1, 5'd1, 3'b000, 5'd1, opc_imm); // JAL shadow
        imem[base_idx + 3] = rtype(7'h00, 5'd1, 5'd7, 5'd6);            // Return lands here
        imem[base_idx + 4] = stype(res_addr[11:0], 5'd6, 5'd0);
        imem[base_idx + 5] = itype(12'd0, 5'd5, 3'b000, 5'd7, opc_imm); // Subroutine copies the link
        imem[base_idx + 6] = itype(12'd4, 5'd5, 3'b000, 5'd5, opc_imm); // Step over shadow
        imem[base_idx + 7] = itype(12'd0, 5'd5, 3'b000, 5'd0, opc_jalr);
        imem[base_idx + 8] = stype(stray_addr[11:0], 5'd1, 5'd0);       // JR shadow
      end
    endcase
  endtask

  // ==========================================================
  // Row execution and checks
  // ==========================================================

  task automatic run_row(input int r);
    int   cyc;
    int   holds;
    logic done;
    @(posedge clk);
    #1;
    rst = 1'b1;
    load_row(rows[r]);
    @(posedge clk);
    @(negedge clk);
    if (dmemreq_val) begin
      $display("row %0d: data memory request while reset is held", r);
      errors++;
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    done  = 1'b0;
    cyc   = 0;
    holds = 0;
    while (!done && cyc < row_limit) begin
      @(negedge clk);
      cyc++;
      if (cyc == 1) begin
        // First fetch after reset comes from the reset vector
        if (imemreq_val != 1'b1) begin
          $display("[FAIL] row %0d imemreq_val expected %h got %h", r, 1'b1, imemreq_val);
          errors++;
        end
        if (imemreq_addr != prog_base) begin
          $display("[FAIL] row %0d imemreq_addr expected %h got %h",
                   r, prog_base, imemreq_addr);
          errors++;
        end
      end
      if (!imemreq_val) holds++;
      if (dmemreq_val && dmemreq_type) begin
        dmem[dmemreq_addr[9:2]] = dmemreq_wdata;
        if (dmemreq_addr != res_addr) begin
          $display("[FAIL] row %0d dmemreq_addr expected %h got %h", r, res_addr, dmemreq_addr);
          errors++;
        end else begin
          done = 1'b1;
          if (dmemreq_wdata != rows[r].expected) begin
            $display("[FAIL] row %0d dmemreq_wdata expected %h got %h",
                     r, rows[r].expected, dmemreq_wdata);
            errors++;
          end
        end
      end
    end
    if (!done) begin
      $display("row %0d: no store to the result address within %0d cycles", r, row_limit);
      errors++;
    end else if (holds != load_use_stalls(rows[r].tmpl)) begin
      $display("row %0d: fetch held for %0d cycles but the program has %0d load-use stalls",
               r, holds, load_use_stalls(rows[r].tmpl));
      errors++;
    end
  endtask

  initial begin
    int          i;
    logic [2:0]  tmpl;
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    clk     = 1'b0;
    rst     = 1'b1;
    errors  = 0;
    row_cnt = 0;
    rng     = 32'h6e1aa8d5;
    fill_memories();

    add_row(t_add, 32'd5, 32'd7, 12'h000, 32'd12);
    add_row(t_add, 32'hffff_ffff, 32'd2, 12'h000, 32'd1);
    add_row(t_mul, 32'd6, 32'd7, 12'h000, 32'd42);
    add_row(t_mul, 32'h0001_0000, 32'h0001_0003, 12'h000, 32'h0003_0000);
    add_row(t_addi, 32'd100, 32'd20, 12'h003, 32'd123);
    add_row(t_addi, 32'd10, 32'h0000_0fff, 12'hffe, 32'd7);   // Both immediates negative
    add_row(t_bne, 32'd9, 32'd4, 12'h032, 32'd9);              // Taken
    add_row(t_bne, 32'd9, 32'd9, 12'h032, 32'd59);             // Not taken
    add_row(t_jal, 32'd1000, 32'd0, 12'h000, 32'd1000 + 32'h208);

    for (i = 0; i < n_rand; i++) begin
      rng  = xorshift32(rng);
      a    = rng;
      rng  = xorshift32(rng);
      b    = rng;
      rng  = xorshift32(rng);
      tmpl = 3'(rng % 5);
      imm  = rng[19:8];
      add_row(tmpl, a, b, imm, ref_result(tmpl, a, b, imm));
    end

    for (i = 0; i < n_rows; i++) begin
      run_row(i);
    end

    $display("%0d errors in %0d rows", errors, n_rows);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns without the test table finishing", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
